// File: Bender.yml
package:
  name: io_subsys

sources:
  - io_pkg.sv
  - uart_tx.sv
  - uart_rx.sv
  - perf_counters.sv
  - io_apb_regs.sv
  - io_subsys.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_io_subsys.sv

// File: io_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_apb_regs (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire io_pkg::apb_req_t      apb_req,
    output io_pkg::apb_rsp_t           apb_rsp,
    output io_pkg::byte_t              tx_data,
    output logic                       tx_valid,
    input  wire logic                  tx_ready,
    input  wire io_pkg::byte_t         rx_data,
    input  wire logic                  rx_valid,
    output logic                       rx_ready,
    output logic                       cnt_clear,
    input  wire io_pkg::perf_counts_t  counts
);
    import io_pkg::*;

    logic  capture;
    word_t rdata_d;
    logic  err_d;
    logic  tx_load;
    logic  rx_pop;
    logic  clear_req;

    // the first access cycle always ends without pready, giving one wait state
    assign capture = apb_req.psel && apb_req.penable && !apb_rsp.pready;

    always_comb begin
        rdata_d   = '0;
        err_d     = 1'b0;
        tx_load   = 1'b0;
        rx_pop    = 1'b0;
        clear_req = 1'b0;
        case (apb_req.paddr)
            REG_UART_CTRL: begin
                if (apb_req.pwrite) begin
                    err_d = 1'b1;
                end else begin
                    rdata_d = {30'b0, rx_valid, tx_ready};
                end
            end
            REG_UART_RDATA: begin
                if (apb_req.pwrite || !rx_valid) begin
                    err_d = 1'b1;
                end else begin
                    rdata_d = word_t'(rx_data);
                    rx_pop  = 1'b1;
                end
            end
            REG_UART_TDATA: begin
                // a busy transmitter refuses the byte
                if (apb_req.pwrite && tx_ready) begin
                    tx_load = 1'b1;
                end else begin
                    err_d = 1'b1;
                end
            end
            REG_CYCLE_CNT: begin
                err_d   = apb_req.pwrite;
                rdata_d = apb_req.pwrite ? '0 : word_t'(counts.cycle);
            end
            REG_INST_CNT: begin
                err_d   = apb_req.pwrite;
                rdata_d = apb_req.pwrite ? '0 : word_t'(counts.inst);
            end
            REG_RST_CNT: begin
                if (apb_req.pwrite) begin
                    clear_req = 1'b1;
                end else begin
                    err_d = 1'b1;
                end
            end
            REG_BR_INST_CNT: begin
                err_d   = apb_req.pwrite;
                rdata_d = apb_req.pwrite ? '0 : word_t'(counts.br_inst);
            end
            REG_BR_SUC_CNT: begin
                err_d   = apb_req.pwrite;
                rdata_d = apb_req.pwrite ? '0 : word_t'(counts.br_suc);
            end
            default: begin
                err_d = 1'b1;
            end
        endcase
    end

    // the counters clear and the receiver pops on the capture edge itself
    assign rx_ready  = capture && rx_pop;
    assign cnt_clear = capture && clear_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            apb_rsp  <= '0;
            tx_valid <= 1'b0;
        end else begin
            if (tx_valid && tx_ready) begin
                tx_valid <= 1'b0;
            end
            if (capture) begin
                apb_rsp.pready  <= 1'b1;
                apb_rsp.prdata  <= rdata_d;
                apb_rsp.pslverr <= err_d;
                if (tx_load) begin
                    tx_valid <= 1'b1;
                end
            end else if (apb_rsp.pready) begin
                apb_rsp <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture && tx_load) begin
            tx_data <= apb_req.pwdata[7:0];
        end
    end

endmodule

`default_nettype wire

// File: io_pkg.sv
`default_nettype none

package io_pkg;

    localparam int BYTE_W      = 8;
    localparam int WORD_W      = 32;
    localparam int ADDR_W      = 8;
    localparam int CYCLE_CNT_W = 28;
    localparam int EVENT_CNT_W = 24;

    typedef logic [BYTE_W-1:0]      byte_t;
    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [ADDR_W-1:0]      io_addr_t;
    typedef logic [CYCLE_CNT_W-1:0] cycle_cnt_t;
    typedef logic [EVENT_CNT_W-1:0] event_cnt_t;

    // addi x0, x0, 0 marks an empty retire slot
    localparam word_t NOP_INST = 32'h0000_0013;

    // register offsets inside the I/O window
    localparam io_addr_t REG_UART_CTRL   = 8'h00;
    localparam io_addr_t REG_UART_RDATA  = 8'h04;
    localparam io_addr_t REG_UART_TDATA  = 8'h08;
    localparam io_addr_t REG_CYCLE_CNT   = 8'h10;
    localparam io_addr_t REG_INST_CNT    = 8'h14;
    localparam io_addr_t REG_RST_CNT     = 8'h18;
    localparam io_addr_t REG_BR_INST_CNT = 8'h1C;
    localparam io_addr_t REG_BR_SUC_CNT  = 8'h20;

    localparam int CLOCK_FREQ   = 50_000_000;
    localparam int BAUD_RATE    = 3_125_000;
    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;

    typedef struct packed {
        logic     psel;
        logic     penable;
        logic     pwrite;
        io_addr_t paddr;
        word_t    pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    // one cycle of the retire stage with its integer and floating-point slots
    typedef struct packed {
        word_t inst;
        word_t fp_inst;
        logic  br_inst;
        logic  br_suc;
    } retire_t;

    typedef struct packed {
        cycle_cnt_t cycle;
        event_cnt_t inst;
        event_cnt_t br_inst;
        event_cnt_t br_suc;
    } perf_counts_t;

endpackage

`default_nettype wire

// File: io_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module io_subsys (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire io_pkg::apb_req_t apb_req,
    output io_pkg::apb_rsp_t      apb_rsp,
    input  wire io_pkg::retire_t  retire,
    input  wire logic             serial_in,
    output logic                  serial_out
);
    import io_pkg::*;

    byte_t        tx_data;
    logic         tx_valid;
    logic         tx_ready;
    byte_t        rx_data;
    logic         rx_valid;
    logic         rx_ready;
    logic         cnt_clear;
    perf_counts_t counts;

    io_apb_regs regs_i (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .cnt_clear (cnt_clear),
        .counts    (counts)
    );

    perf_counters counters_i (
        .clk    (clk),
        .rst    (rst),
        .retire (retire),
        .clear  (cnt_clear),
        .counts (counts)
    );

    uart_tx #(
        .clks_per_bit (CLKS_PER_BIT)
    ) uart_tx_i (
        .clk        (clk),
        .rst        (rst),
        .data       (tx_data),
        .valid      (tx_valid),
        .ready      (tx_ready),
        .serial_out (serial_out)
    );

    uart_rx #(
        .clks_per_bit (CLKS_PER_BIT)
    ) uart_rx_i (
        .clk       (clk),
        .rst       (rst),
        .serial_in (serial_in),
        .data      (rx_data),
        .valid     (rx_valid),
        .ready     (rx_ready)
    );

endmodule

`default_nettype wire

// File: perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire io_pkg::retire_t      retire,
    input  wire logic                 clear,
    output io_pkg::perf_counts_t      counts
);
    import io_pkg::*;

    logic       int_valid;
    logic       fp_valid;
    logic [1:0] inst_inc;

    assign int_valid = (retire.inst != NOP_INST);
    assign fp_valid  = (retire.fp_inst != NOP_INST);

    // both slots can retire in the same cycle
    assign inst_inc = {1'b0, int_valid} + {1'b0, fp_valid};

    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else if (clear) begin
            // events sampled on the clear edge itself are discarded
            counts <= '0;
        end else begin
            counts.cycle   <= counts.cycle + 1'b1;
            counts.inst    <= counts.inst + event_cnt_t'(inst_inc);
            counts.br_inst <= counts.br_inst + event_cnt_t'(retire.br_inst);
            counts.br_suc  <= counts.br_suc + event_cnt_t'(retire.br_suc);
        end
    end

endmodule

`default_nettype wire

// File: sources.f
io_pkg.sv
uart_tx.sv
uart_rx.sv
perf_counters.sv
io_apb_regs.sv
io_subsys.sv
tb_clock_gen.sv
tb_io_subsys.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real period_ns = 20.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: tb_io_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_io_subsys;
    import io_pkg::*;

    localparam int      TIMEOUT_CYCLES = 40_000;
    localparam int      TX_FRAMES      = 12;
    localparam int      RX_FRAMES      = 12;
    localparam int      MAX_POLLS      = 100;
    localparam retire_t IDLE_RETIRE    = {NOP_INST, NOP_INST, 2'b00};

    logic     clk;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    retire_t  retire;
    logic     serial_in;
    logic     serial_out;

    int unsigned edge_cnt = 0;
    int unsigned last_clear_edge;
    int unsigned last_capture_edge;
    logic        retire_stop;
    byte_t       tx_expected [$];
    // retire port contents sampled at every rising edge and indexed by edge number
    retire_t     retire_hist [0:TIMEOUT_CYCLES];

    tb_clock_gen #(.period_ns(20.0)) clk_gen_i (.clk(clk));

    io_subsys dut_i (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .retire     (retire),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp,
                              input logic got_err, input logic exp_err);
        if (got !== exp) begin
            $display("Error: %s prdata got 0x%08h expected 0x%08h", name, got, exp);
            abort_run();
        end else if (got_err !== exp_err) begin
            $display("Error: %s pslverr got 0x%0h expected 0x%0h", name, got_err, exp_err);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%02h expected 0x%02h", name, got, exp);
            abort_run();
        end
    endtask

    // counters hold every event sampled strictly between the clear and capture edges
    function automatic word_t expected_reg(input io_addr_t addr, input int unsigned clear_edge,
                                           input int unsigned capture_edge,
                                           input logic tx_idle, input logic rx_held);
        cycle_cnt_t cyc;
        event_cnt_t inst;
        event_cnt_t br_inst;
        event_cnt_t br_suc;
        cyc     = '0;
        inst    = '0;
        br_inst = '0;
        br_suc  = '0;
        for (int unsigned e = clear_edge + 1; e < capture_edge; e++) begin
            cyc = cyc + 1'b1;
            if (retire_hist[e].inst != NOP_INST) inst = inst + 1'b1;
            if (retire_hist[e].fp_inst != NOP_INST) inst = inst + 1'b1;
            br_inst = br_inst + event_cnt_t'(retire_hist[e].br_inst);
            br_suc  = br_suc + event_cnt_t'(retire_hist[e].br_suc);
        end
        case (addr)
            REG_UART_CTRL:   return {30'b0, rx_held, tx_idle};
            REG_CYCLE_CNT:   return word_t'(cyc);
            REG_INST_CNT:    return word_t'(inst);
            REG_BR_INST_CNT: return word_t'(br_inst);
            REG_BR_SUC_CNT:  return word_t'(br_suc);
            default:         return '0;
        endcase
    endfunction

    task automatic bus_transfer(input logic write, input io_addr_t addr, input word_t wdata,
                                output word_t rdata, output logic err);
        int unsigned waits;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable   = 1'b1;
        last_capture_edge = edge_cnt + 1;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (apb_rsp.pready !== 1'b1 && waits < 4);
        if (waits != 1) begin
            $display("pready did not come after exactly one wait state at offset 0x%02h", addr);
            abort_run();
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        if (write && addr == REG_RST_CNT) last_clear_edge = last_capture_edge;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input io_addr_t addr, input word_t wdata,
                             output word_t rdata, output logic err);
        bus_transfer(1'b1, addr, wdata, rdata, err);
    endtask

    task automatic apb_read(input io_addr_t addr, output word_t rdata, output logic err);
        bus_transfer(1'b0, addr, '0, rdata, err);
    endtask

    task automatic wait_ctrl_bit(input int idx, input string what);
        word_t rdata;
        logic  err;
        int    polls;
        polls = 0;
        rdata = '0;
        while (rdata[idx] !== 1'b1) begin
            if (polls == MAX_POLLS) begin
                $display("%s never showed up in the CTRL register", what);
                abort_run();
            end
            apb_read(REG_UART_CTRL, rdata, err);
            polls++;
        end
    endtask

    task automatic serialize_byte(input byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            serial_in = frame[i];
            repeat (CLKS_PER_BIT - 1) @(negedge clk);
        end
    endtask

    task automatic drive_random_retire();
        while (!retire_stop) begin
            @(negedge clk);
            retire.inst    = ($urandom_range(1) == 0) ? NOP_INST : word_t'($urandom);
            retire.fp_inst = ($urandom_range(1) == 0) ? NOP_INST : word_t'($urandom);
            retire.br_inst = ($urandom_range(1) == 1);
            retire.br_suc  = ($urandom_range(1) == 1);
        end
        retire = IDLE_RETIRE;
    endtask

    task automatic transmit_frames();
        word_t rdata;
        logic  err;
        byte_t value;
        for (int i = 0; i < TX_FRAMES; i++) begin
            value = byte_t'($urandom);
            wait_ctrl_bit(0, "tx ready");
            apb_write(REG_UART_TDATA, word_t'(value), rdata, err);
            check_word("TDATA write", rdata, '0, err, 1'b0);
            tx_expected.push_back(value);
            // the transmitter has just taken a byte and must refuse this one
            apb_write(REG_UART_TDATA, word_t'(~value), rdata, err);
            check_word("TDATA busy write", rdata, '0, err, 1'b1);
        end
        while (tx_expected.size() != 0) @(negedge clk);
        repeat (10 * CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic receive_frames();
        word_t rdata;
        logic  err;
        byte_t value;
        apb_read(REG_UART_RDATA, rdata, err);
        check_word("RDATA empty", rdata, '0, err, 1'b1);
        for (int i = 0; i < RX_FRAMES; i++) begin
            value = byte_t'($urandom);
            serialize_byte(value);
            wait_ctrl_bit(1, "rx valid");
            apb_read(REG_UART_RDATA, rdata, err);
            check_byte("RDATA", byte_t'(rdata), value);
            check_word("RDATA", rdata, word_t'(value), err, 1'b0);
            apb_read(REG_UART_CTRL, rdata, err);
            check_word("CTRL", rdata, expected_reg(REG_UART_CTRL, 0, 0, 1'b1, 1'b0), err, 1'b0);
        end
    endtask

    task automatic count_retired();
        word_t    rdata;
        logic     err;
        io_addr_t regs [3] = '{REG_INST_CNT, REG_BR_INST_CNT, REG_BR_SUC_CNT};
        for (int round = 0; round < 3; round++) begin
            retire_stop = 1'b0;
            fork
                drive_random_retire();
                begin
                    apb_write(REG_RST_CNT, '0, rdata, err);
                    check_word("RST_CNT write", rdata, '0, err, 1'b0);
                    repeat ($urandom_range(20, 80)) @(negedge clk);
                    foreach (regs[k]) begin
                        apb_read(regs[k], rdata, err);
                        check_word($sformatf("counter at 0x%02h", regs[k]), rdata,
                                   expected_reg(regs[k], last_clear_edge, last_capture_edge,
                                                1'b1, 1'b0), err, 1'b0);
                    end
                    retire_stop = 1'b1;
                end
            join
        end
    endtask

    task automatic read_cycle_cnt();
        word_t rdata;
        logic  err;
        apb_read(REG_CYCLE_CNT, rdata, err);
        check_word("CYCLE_CNT", rdata, expected_reg(REG_CYCLE_CNT, last_clear_edge,
                   last_capture_edge, 1'b1, 1'b0), err, 1'b0);
    endtask

    task automatic time_cycles();
        word_t rdata;
        logic  err;
        for (int i = 0; i < 4; i++) begin
            apb_write(REG_RST_CNT, '0, rdata, err);
            check_word("RST_CNT write", rdata, '0, err, 1'b0);
            repeat ($urandom_range(5, 200)) @(negedge clk);
            read_cycle_cnt();
        end
    endtask

    task automatic probe_bad_accesses();
        word_t rdata;
        logic  err;
        apb_read(8'h24, rdata, err);
        check_word("unmapped read", rdata, '0, err, 1'b1);
        apb_write(8'hFC, 32'hDEAD_BEEF, rdata, err);
        check_word("unmapped write", rdata, '0, err, 1'b1);
        apb_read(REG_RST_CNT, rdata, err);
        check_word("RST_CNT read", rdata, '0, err, 1'b1);
        apb_write(REG_UART_CTRL, 32'h3, rdata, err);
        check_word("CTRL write", rdata, '0, err, 1'b1);
        apb_write(REG_CYCLE_CNT, 32'hFFFF_FFFF, rdata, err);
        check_word("CYCLE_CNT write", rdata, '0, err, 1'b1);
        read_cycle_cnt();
    endtask

    always @(posedge clk) begin
        edge_cnt = edge_cnt + 1;
        if (edge_cnt <= TIMEOUT_CYCLES) retire_hist[edge_cnt] = retire;
        if (edge_cnt == TIMEOUT_CYCLES) begin
            $display("the run hit its limit of %0d cycles before the tests ended", edge_cnt);
            abort_run();
        end
    end

    // decodes serial_out at mid-bit and matches each frame against the accepted bytes
    initial begin : tx_monitor
        byte_t got;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (serial_out === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                if (serial_out !== 1'b0) begin
                    $display("start bit on serial_out did not last until mid-bit");
                    abort_run();
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    got[i] = serial_out;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (serial_out !== 1'b1) begin
                    $display("stop bit on serial_out was low");
                    abort_run();
                end
                if (tx_expected.size() == 0) begin
                    $display("a frame appeared on serial_out with no byte accepted for it");
                    abort_run();
                end
                check_byte("serial_out", got, tx_expected.pop_front());
            end
        end
    end

    initial begin : main
        word_t rdata;
        logic  err;
        void'($urandom(72));
        rst         = 1'b1;
        apb_req     = '0;
        retire      = IDLE_RETIRE;
        serial_in   = 1'b1;
        retire_stop = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst             = 1'b0;
        last_clear_edge = edge_cnt;

        apb_read(REG_UART_CTRL, rdata, err);
        check_word("CTRL", rdata, expected_reg(REG_UART_CTRL, 0, 0, 1'b1, 1'b0), err, 1'b0);
        check_byte("serial_out", byte_t'(serial_out), 8'h01);

        transmit_frames();
        receive_frames();
        count_retired();
        time_cycles();
        probe_bad_accesses();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int clks_per_bit = io_pkg::CLKS_PER_BIT
) (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   serial_in,
    output io_pkg::byte_t data,
    output logic        valid,
    input  wire logic   ready
);
    import io_pkg::*;

    localparam int CNT_W = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(clks_per_bit - 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'((clks_per_bit - 1) / 2);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_t;

    rx_state_t        state;
    logic [1:0]       sync_q;
    logic             line;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift_q;
    logic             frame_ok;

    // two flops bring the asynchronous line into the clock domain
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], serial_in};
        end
    end

    assign line = sync_q[1];

    // a good stop bit seen at its middle completes the frame
    assign frame_ok = (state == STOP) && (clk_cnt == LAST) && line;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (!line) begin
                        state <= START;
                    end
                end
                START: begin
                    // a start bit that has gone high again by mid-bit was a glitch
                    if (clk_cnt == HALF) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= line ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (clk_cnt == LAST) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (clk_cnt == LAST) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA && clk_cnt == LAST) begin
            shift_q <= {line, shift_q[7:1]};
        end
    end

    // the holding register keeps its byte until popped and later frames are lost
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (valid) begin
            if (ready) begin
                valid <= 1'b0;
            end
        end else if (frame_ok) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_ok && !valid) begin
            data <= shift_q;
        end
    end

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = io_pkg::CLKS_PER_BIT
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire io_pkg::byte_t data,
    input  wire logic          valid,
    output logic               ready,
    output logic               serial_out
);
    import io_pkg::*;

    localparam int CNT_W = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(clks_per_bit - 1);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift_q;
    logic             bit_end;

    assign bit_end = (clk_cnt == LAST);
    assign ready   = (state == IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            serial_out <= 1'b1;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (valid) begin
                        state      <= START;
                        serial_out <= 1'b0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state      <= DATA;
                        bit_idx    <= '0;
                        serial_out <= shift_q[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state      <= STOP;
                            serial_out <= 1'b1;
                        end else begin
                            serial_out <= shift_q[1];
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // lsb goes out first, so the register shifts right after each data bit
    always_ff @(posedge clk) begin
        if (ready && valid) begin
            shift_q <= data;
        end else if (state == DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire
